//--- build.f
exec_pkg.sv
stage_reg.sv
exec_ctrl.sv
operand_select.sv
alu.sv
branch_unit.sv
execute_top.sv
tb_execute_sva.sv
tb_execute.sv

//--- tb_execute.sv
`timescale 1ns/1ns
`default_nettype none

module tb_execute;

    localparam int ACK_TIMEOUT = 20;  // Cycles allowed for any ack wait

    logic                clk;
    logic                rst;
    logic                req;
    exec_pkg::exec_req_t req_data;
    logic                ack;
    exec_pkg::exec_rsp_t rsp;

    exec_pkg::exec_rsp_t exp_rsp;  // Expected response of the op in flight
    integer              seed;
    int                  value_errors = 0;
    int                  timeout_errors = 0;

    // Sign boundary corners for the ALU sweep
    logic [31:0] corners [5] = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0, 32'h1};
    // Equal, greater and lesser pairs, some negative
    logic [31:0] pair_a [6] = '{32'h5, 32'h7, 32'h3, 32'hffff_fff0, 32'h10, 32'h8000_0000};
    logic [31:0] pair_b [6] = '{32'h5, 32'h3, 32'h7, 32'h10, 32'hffff_fff0, 32'h7fff_ffff};
    exec_pkg::branch_fn_e conds [6] = '{exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
                                        exec_pkg::BGE, exec_pkg::BLTU, exec_pkg::BGEU};
    exec_pkg::op_class_e other_cls [5] = '{exec_pkg::CLS_MEM, exec_pkg::CLS_LUI,
                                           exec_pkg::CLS_AUIPC, exec_pkg::CLS_JAL,
                                           exec_pkg::CLS_JALR};

    execute_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    function automatic logic [31:0] apply_alu_fn(input exec_pkg::alu_fn_e fn,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (fn)
            exec_pkg::ADD:  return a + b;
            exec_pkg::SUB:  return a - b;
            exec_pkg::SLL:  return a << b[4:0];
            exec_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::XOR:  return a ^ b;
            exec_pkg::SRL:  return a >> b[4:0];
            exec_pkg::SRA:  return $unsigned($signed(a) >>> b[4:0]);
            exec_pkg::OR:   return a | b;
            exec_pkg::AND:  return a & b;
            default:        return 32'd0;
        endcase
    endfunction

    // Reference model of the execute stage response
    function automatic exec_pkg::exec_rsp_t exec_model(input exec_pkg::exec_req_t r);
        exec_pkg::exec_rsp_t m;
        logic [31:0]         sum;
        logic                taken;
        m = '0;
        m.store_data = r.rs2_value;
        m.rd         = r.rd;
        m.reg_write  = r.reg_write;
        m.mem_read   = r.mem_read;
        m.mem_write  = r.mem_write;
        sum          = r.rs1_value + r.imm;
        case (r.branch_fn)
            exec_pkg::BEQ:  taken = (r.rs1_value == r.rs2_value);
            exec_pkg::BNE:  taken = (r.rs1_value != r.rs2_value);
            exec_pkg::BLT:  taken = ($signed(r.rs1_value) < $signed(r.rs2_value));
            exec_pkg::BGE:  taken = ($signed(r.rs1_value) >= $signed(r.rs2_value));
            exec_pkg::BLTU: taken = (r.rs1_value < r.rs2_value);
            exec_pkg::BGEU: taken = (r.rs1_value >= r.rs2_value);
            default:        taken = 1'b0;  // Codes 2 and 3
        endcase
        case (r.op_class)
            exec_pkg::CLS_MEM:   m.result = sum;
            exec_pkg::CLS_REG:   m.result = apply_alu_fn(r.alu_fn, r.rs1_value, r.rs2_value);
            exec_pkg::CLS_IMM:   m.result = apply_alu_fn(r.alu_fn, r.rs1_value, r.imm);
            exec_pkg::CLS_LUI:   m.result = r.imm;
            exec_pkg::CLS_AUIPC: m.result = r.pc + r.imm;
            exec_pkg::CLS_BRANCH:
            begin
                m.result   = r.rs1_value - r.rs2_value;
                m.redirect = taken;
                m.target   = r.pc + r.imm;
            end
            exec_pkg::CLS_JAL:
            begin
                m.result   = r.pc + 32'd4;
                m.redirect = 1'b1;
                m.target   = r.pc + r.imm;
            end
            default:  // JALR
            begin
                m.result   = r.pc + 32'd4;
                m.redirect = 1'b1;
                m.target   = {sum[31:1], 1'b0};
            end
        endcase
        return m;
    endfunction

    task automatic random_req(input exec_pkg::op_class_e cls, output exec_pkg::exec_req_t r);
        logic [31:0] bits;
        bits        = $random(seed);
        r.op_class  = cls;
        r.alu_fn    = exec_pkg::ADD;
        r.branch_fn = exec_pkg::BEQ;
        r.rs1_value = $random(seed);
        r.rs2_value = $random(seed);
        r.imm       = $random(seed);
        r.pc        = $random(seed) & 32'hffff_fffc;  // Word aligned PC
        r.rd        = bits[4:0];
        r.reg_write = bits[5];
        r.mem_read  = bits[6];
        r.mem_write = bits[7];
    endtask

    // One full four-phase transfer, with random back-pressure after ack
    task automatic run_op(input exec_pkg::exec_req_t r);
        int                  cycles;
        int                  extra;
        exec_pkg::exec_req_t junk;
        exp_rsp  = exec_model(r);
        req_data = r;
        req      = 1'b1;
        cycles   = 0;
        while (!ack && cycles < ACK_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ack)
        begin
            $display("Timeout: ack did not rise within %0d cycles", ACK_TIMEOUT);
            timeout_errors++;
        end
        else
        begin
            check_value("ack_latency", 32'd2, cycles - 1);  // First edge sampled req
            extra = $unsigned($random(seed)) % 4;
            junk  = r;
            repeat (extra)
            begin
                junk.rs1_value = $random(seed);  // New data must be ignored in DONE
                junk.imm       = $random(seed);
                req_data       = junk;
                @(posedge clk);
                #1;
                check_value("ack", 32'd1, {31'd0, ack});
            end
        end
        req    = 1'b0;
        cycles = 0;
        while (ack && cycles < ACK_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (ack)
        begin
            $display("Timeout: ack did not fall within %0d cycles after req", ACK_TIMEOUT);
            timeout_errors++;
        end
    endtask

    // Compare process, rsp checked on every falling edge with ack high
    always @(negedge clk)
    begin
        if (!rst && ack)
        begin
            check_value("rsp.result", exp_rsp.result, rsp.result);
            check_value("rsp.store_data", exp_rsp.store_data, rsp.store_data);
            check_value("rsp.target", exp_rsp.target, rsp.target);
            check_value("rsp.rd", {27'd0, exp_rsp.rd}, {27'd0, rsp.rd});
            check_value("rsp.reg_write", {31'd0, exp_rsp.reg_write}, {31'd0, rsp.reg_write});
            check_value("rsp.mem_read", {31'd0, exp_rsp.mem_read}, {31'd0, rsp.mem_read});
            check_value("rsp.mem_write", {31'd0, exp_rsp.mem_write}, {31'd0, rsp.mem_write});
            check_value("rsp.redirect", {31'd0, exp_rsp.redirect}, {31'd0, rsp.redirect});
        end
    end

    initial
    begin
        exec_pkg::exec_req_t r;
        seed     = 32'h1619_363a;
        req      = 1'b0;
        req_data = '0;
        exp_rsp  = '0;
        rst      = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        check_value("ack", 32'd0, {31'd0, ack});  // Idle after reset
        check_value("rsp.redirect", 32'd0, {31'd0, rsp.redirect});

        // ALU sweep, even n register form, odd n immediate form
        for (int k = 0; k < 10; k++)
        begin
            for (int n = 0; n < 8; n++)
            begin
                random_req(n[0] ? exec_pkg::CLS_IMM : exec_pkg::CLS_REG, r);
                r.alu_fn = exec_pkg::alu_fn_e'(k);
                if (n < 4)
                begin
                    r.rs1_value = corners[n];
                    r.rs2_value = corners[n + 1];
                    r.imm       = corners[4 - n];
                end
                run_op(r);
            end
        end

        // Branch conditions, each followed by an unused code
        for (int c = 0; c < 6; c++)
        begin
            for (int p = 0; p < 6; p++)
            begin
                random_req(exec_pkg::CLS_BRANCH, r);
                r.rs1_value = pair_a[p];
                r.rs2_value = pair_b[p];
                r.branch_fn = conds[c];
                run_op(r);
                r.branch_fn = exec_pkg::branch_fn_e'(3'd2 + {2'd0, p[0]});
                run_op(r);
            end
        end

        // Memory, upper immediate and jump classes
        for (int c = 0; c < 5; c++)
        begin
            for (int n = 0; n < 6; n++)
            begin
                random_req(other_cls[c], r);
                run_op(r);
            end
        end
        random_req(exec_pkg::CLS_JALR, r);
        r.rs1_value = 32'h0000_1001;  // Odd sum, bit 0 must clear
        r.imm       = 32'h0000_0004;
        run_op(r);

        $display("Checks done: %0d value errors, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_execute_sva.sv
`timescale 1ns/1ns
`default_nettype none

// Four-phase handshake properties of the execute stage
module tb_execute_sva (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                req,
    input wire logic                ack,
    input wire exec_pkg::exec_rsp_t rsp
);

    // ack is registered, so the request is checked one sample back
    a_ack_rise_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    a_ack_held_with_req: assert property (@(posedge clk) disable iff (rst)
        $fell(ack) |-> !$past(req))
        else $error("ack fell while req was still high");

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        ack |-> $stable(rsp))
        else $error("rsp changed while ack was high");

    // ack set at the second edge after req was sampled, seen one sample later
    a_ack_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> ##3 $rose(ack))
        else $error("ack latency differs from two cycles");

endmodule

bind execute_top tb_execute_sva i_sva (
    .clk (clk),
    .rst (rst),
    .req (req),
    .ack (ack),
    .rsp (rsp)
);

`default_nettype wire

//--- execute_top.sv
`timescale 1ns/1ns
`default_nettype none

// Execute stage subsystem with a four-phase req/ack boundary
module execute_top (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req,
    input  wire exec_pkg::exec_req_t req_data,  // Stable while req is high
    output logic                     ack,
    output exec_pkg::exec_rsp_t      rsp        // Valid while ack is high
);

    logic                capture;
    logic                commit;
    exec_pkg::exec_req_t req_q;     // Instruction in flight
    exec_pkg::alu_op_t   alu_cmd;
    logic [31:0]         alu_result;
    logic                redirect;
    logic [31:0]         target;
    exec_pkg::exec_rsp_t rsp_next;  // Response before commit

    exec_ctrl i_ctrl (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .capture (capture),
        .commit  (commit)
    );

    // Input side of the stage
    stage_reg #(
        .T (exec_pkg::exec_req_t)
    ) i_req_reg (
        .clk  (clk),
        .rst  (rst),
        .load (capture),
        .d    (req_data),
        .q    (req_q)
    );

    operand_select i_opsel (
        .req (req_q),
        .op  (alu_cmd)
    );

    alu i_alu (
        .op     (alu_cmd),
        .result (alu_result)
    );

    branch_unit i_branch (
        .req      (req_q),
        .redirect (redirect),
        .target   (target)
    );

    always_comb
    begin
        rsp_next.result     = alu_result;
        rsp_next.store_data = req_q.rs2_value;  // Store data is always rs2
        rsp_next.target     = target;
        // Write-back and memory controls pass straight through
        rsp_next.rd         = req_q.rd;
        rsp_next.reg_write  = req_q.reg_write;
        rsp_next.mem_read   = req_q.mem_read;
        rsp_next.mem_write  = req_q.mem_write;
        rsp_next.redirect   = redirect;
    end

    // Output side, holds rsp until the next commit
    stage_reg #(
        .T (exec_pkg::exec_rsp_t)
    ) i_rsp_reg (
        .clk  (clk),
        .rst  (rst),
        .load (commit),
        .d    (rsp_next),
        .q    (rsp)
    );

endmodule

`default_nettype wire

//--- branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

// Branch decision and next-PC target
module branch_unit (
    input  wire exec_pkg::exec_req_t req,
    output logic                     redirect,
    output logic [31:0]              target
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;  // Condition result, before class check

    // Direct compares, independent of the ALU
    assign eq   = req.rs1_value == req.rs2_value;
    assign lt_s = $signed(req.rs1_value) < $signed(req.rs2_value);
    assign lt_u = req.rs1_value < req.rs2_value;

    always_comb
    begin
        case (req.branch_fn)
            exec_pkg::BEQ:  taken = eq;
            exec_pkg::BNE:  taken = !eq;
            exec_pkg::BLT:  taken = lt_s;
            exec_pkg::BGE:  taken = !lt_s;
            exec_pkg::BLTU: taken = lt_u;
            exec_pkg::BGEU: taken = !lt_u;
            default:        taken = 1'b0;  // Illegal codes never branch
        endcase
    end

    always_comb
    begin
        redirect = 1'b0;
        target   = 32'd0;
        case (req.op_class)
            exec_pkg::CLS_BRANCH:
            begin
                redirect = taken;
                target   = req.pc + req.imm;  // Target valid even when not taken
            end
            exec_pkg::CLS_JAL:
            begin
                redirect = 1'b1;
                target   = req.pc + req.imm;
            end
            exec_pkg::CLS_JALR:
            begin
                redirect = 1'b1;
                target   = (req.rs1_value + req.imm) & 32'hffff_fffe;  // LSB cleared
            end
            default:
            begin
                redirect = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ns
`default_nettype none

// RV32I integer ALU, purely combinational
module alu (
    input  wire exec_pkg::alu_op_t op,
    output logic [31:0]            result
);

    logic [4:0] shamt;  // Shift amount
    logic       lt_s;
    logic       lt_u;

    assign shamt = op.b[4:0];  // Upper bits of b ignored for shifts
    assign lt_s  = $signed(op.a) < $signed(op.b);
    assign lt_u  = op.a < op.b;

    always_comb
    begin
        case (op.fn)
            exec_pkg::ADD:  result = op.a + op.b;
            exec_pkg::SUB:  result = op.a - op.b;
            exec_pkg::SLL:  result = op.a << shamt;
            exec_pkg::SLT:  result = {31'd0, lt_s};
            exec_pkg::SLTU: result = {31'd0, lt_u};
            exec_pkg::XOR:  result = op.a ^ op.b;
            exec_pkg::SRL:  result = op.a >> shamt;
            exec_pkg::SRA:  result = $signed(op.a) >>> shamt;  // Sign fill
            exec_pkg::OR:   result = op.a | op.b;
            exec_pkg::AND:  result = op.a & op.b;
            default:
            begin
                result = 32'd0;  // Unused codes
            end
        endcase
    end

endmodule

`default_nettype wire

//--- operand_select.sv
`timescale 1ns/1ns
`default_nettype none

// Operand and function choice per instruction class
module operand_select (
    input  wire exec_pkg::exec_req_t req,
    output exec_pkg::alu_op_t        op
);

    always_comb
    begin
        // Default is the plain register form
        op.fn = exec_pkg::ADD;
        op.a  = req.rs1_value;
        op.b  = req.rs2_value;

        case (req.op_class)
            exec_pkg::CLS_REG:
            begin
                op.fn = req.alu_fn;
            end
            exec_pkg::CLS_IMM:
            begin
                op.fn = req.alu_fn;
                op.b  = req.imm;
            end
            exec_pkg::CLS_MEM:
            begin
                op.b = req.imm;  // Effective address
            end
            exec_pkg::CLS_BRANCH:
            begin
                op.fn = exec_pkg::SUB;  // Difference goes out as result
            end
            exec_pkg::CLS_LUI:
            begin
                op.a = 32'd0;
                op.b = req.imm;  // Upper immediate passes through the adder
            end
            exec_pkg::CLS_AUIPC:
            begin
                op.a = req.pc;
                op.b = req.imm;
            end
            exec_pkg::CLS_JAL, exec_pkg::CLS_JALR:
            begin
                op.a = req.pc;
                op.b = 32'd4;  // Link address
            end
            default:
            begin
                op.fn = exec_pkg::ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- exec_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// Four-phase req/ack controller
// Sequences the request and response registers for one instruction at a time
module exec_ctrl (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic req,
    output logic      ack,
    output logic      capture,  // Load strobe of the request register
    output logic      commit    // Load strobe of the response register
);

    typedef enum logic [1:0]
    {
        IDLE = 2'b00,  // Waiting for req
        EXEC = 2'b01,  // Held request is being evaluated
        DONE = 2'b10   // Response committed, handshake in progress
    } state_t;

    state_t state;

    // Take a new request only from IDLE
    assign capture = (state == IDLE) && req;
    assign commit  = (state == EXEC);  // Combinational result settles in one cycle

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            ack   <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req)
                    begin
                        state <= EXEC;
                    end
                end
                EXEC:
                begin
                    state <= DONE;
                end
                DONE:
                begin
                    // Requester drops req after seeing ack
                    if (!req)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase

            // Rises in the first DONE cycle, two edges after req was sampled
            // Held under back-pressure, cleared at the edge that sees req low
            ack <= (state == DONE) && req;
        end
    end

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

// Pipeline boundary register, payload given by type
module stage_reg #(
    parameter type T = logic
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load,  // Single-cycle load strobe
    input  wire T     d,
    output T          q
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            q <= '0;  // Clear whole payload, redirect starts at 0
        end
        else if (load)
        begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- exec_pkg.sv
`default_nettype none

package exec_pkg;

    // Instruction class as handed over by the decoder
    typedef enum logic [2:0]
    {
        CLS_MEM    = 3'b000,  // Loads and stores, address calculation only
        CLS_BRANCH = 3'b001,  // Conditional branches
        CLS_REG    = 3'b010,  // Register-register ALU ops
        CLS_JAL    = 3'b011,
        CLS_LUI    = 3'b100,  // Immediate arrives pre-shifted
        CLS_AUIPC  = 3'b101,
        CLS_IMM    = 3'b110,  // Register-immediate ALU ops
        CLS_JALR   = 3'b111
    } op_class_e;

    // ALU function, codes 10 to 15 unused
    typedef enum logic [3:0]
    {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } alu_fn_e;

    // Branch condition, same as funct3 of the B-type encoding
    typedef enum logic [2:0]
    {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_fn_e;

    // One decoded instruction
    typedef struct packed
    {
        op_class_e   op_class;
        alu_fn_e     alu_fn;     // Only used for CLS_REG and CLS_IMM
        branch_fn_e  branch_fn;  // Only used for CLS_BRANCH
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] imm;        // Sign extended by the decoder
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
    } exec_req_t;

    // Execute stage result for the memory stage
    typedef struct packed
    {
        logic [31:0] result;
        logic [31:0] store_data;
        logic [31:0] target;     // Zero unless a branch or jump
        logic [4:0]  rd;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        redirect;   // Next PC comes from target
    } exec_rsp_t;

    // ALU command
    typedef struct packed
    {
        alu_fn_e     fn;
        logic [31:0] a;
        logic [31:0] b;
    } alu_op_t;

endpackage

`default_nettype wire
